//--- Bender.yml
package:
  name: stack_core

sources:
  - include_dirs:
      - include
    files:
      - src/core_pkg.sv
      - src/fetch_unit.sv
      - src/execute_control.sv
      - src/alu.sv
      - src/data_stack.sv
      - src/core_bus_port.sv
      - src/core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/core_tb.sv

//--- dv/core_tb.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module core_tb;

  localparam int RUN_TIMEOUT = 500;
  localparam int ACK_TIMEOUT = 50;

  logic                 clk;
  logic                 rst_n;
  core_pkg::instr_t     program_data = '0;
  logic                 send_ack;
  core_pkg::prog_addr_t program_addr;
  core_pkg::mem_write_t mem_write;
  logic                 send_req;
  core_pkg::word_t      send_data;
  logic                 stopped;
  core_pkg::fault_t     fault;

  core_pkg::instr_t    prog_mem [256];
  int                  load_ptr;
  logic [31:0]         rng_state = 32'd10;
  core_pkg::mem_addr_t got_addr [$];
  core_pkg::word_t     got_data [$];
  core_pkg::word_t     got_sends [$];
  core_pkg::mem_addr_t exp_addr [$];
  core_pkg::word_t     exp_data [$];
  core_pkg::word_t     exp_sends [$];
  int                  test_errors;
  int                  total_errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  core_top uut (
    .clk, .rst_n, .program_data, .send_ack, .program_addr, .mem_write,
    .send_req, .send_data, .stopped, .fault
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Program memory with a synchronous read that keeps running in reset
  always @(posedge clk) begin
    program_data <= prog_mem[program_addr];
  end

  // Each write holds we for one full cycle, so one falling edge sees it
  always @(negedge clk) begin
    if (rst_n && mem_write.we) begin
      got_addr.push_back(mem_write.addr);
      got_data.push_back(mem_write.data);
    end
  end

  function automatic logic [31:0] xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Result of a binary op with a as second and b as top
  function automatic core_pkg::word_t alu_rule(core_pkg::instr_t op, core_pkg::word_t a,
                                               core_pkg::word_t b);
    case (op)
      `CORE_OP_ADD: return a + b;
      `CORE_OP_SUB: return a - b;
      `CORE_OP_AND: return a & b;
      `CORE_OP_OR:  return a | b;
      default:      return a ^ b;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    assert (got === expected) else begin
      $display("error: %s expected 0x%h got 0x%h", name, expected, got);
      test_errors++;
    end
  endtask

  task automatic check_idle_outputs();
    check_value("send_req", send_req, 1'b0);
    check_value("mem_write.we", mem_write.we, 1'b0);
    check_value("stopped", stopped, 1'b0);
    check_value("fault", fault, core_pkg::fault_none);
  endtask

  task automatic emit(core_pkg::instr_t code);
    prog_mem[load_ptr] = code;
    load_ptr++;
  endtask

  task automatic push_imm(logic [6:0] value);
    emit(`CORE_PUSHI_FLAG | {1'b0, value});
  endtask

  task automatic binop(logic [6:0] a, logic [6:0] b, core_pkg::instr_t op);
    push_imm(a);
    push_imm(b);
    emit(op);
  endtask

  // Writes the word under the pushed address and records what should appear
  task automatic store_top(logic [6:0] addr, core_pkg::word_t expected);
    push_imm(addr);
    emit(`CORE_OP_WRITE);
    exp_addr.push_back(core_pkg::mem_addr_t'(addr));
    exp_data.push_back(expected);
  endtask

  // Holds the core in reset and clears memory and queues for a new program
  task automatic start_test();
    int a;
    @(negedge clk);
    rst_n = 1'b0;
    send_ack = 1'b0;
    for (a = 0; a < 256; a++) begin
      prog_mem[a] = `CORE_OP_STOP;
    end
    load_ptr = 0;
    got_addr.delete();
    got_data.delete();
    got_sends.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_sends.delete();
    test_errors = 0;
  endtask

  task automatic release_reset();
    int i;
    for (i = 0; i < 5; i++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
  endtask

  task automatic wait_for_stop();
    int cycles;
    cycles = 0;
    while (!stopped && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (stopped) else begin
      $display("timed out waiting for the core to stop");
      test_errors++;
    end
    // Stray writes after the stop would show up here
    repeat (4) @(negedge clk);
  endtask

  task automatic check_results();
    int i;
    assert (got_addr.size() == exp_addr.size()) else begin
      $display("saw %0d memory writes where %0d were expected", got_addr.size(),
               exp_addr.size());
      test_errors++;
    end
    for (i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
      check_value("mem_write.addr", got_addr[i], exp_addr[i]);
      check_value("mem_write.data", got_data[i], exp_data[i]);
    end
    assert (got_sends.size() == exp_sends.size()) else begin
      $display("saw %0d sends where %0d were expected", got_sends.size(), exp_sends.size());
      test_errors++;
    end
    for (i = 0; i < got_sends.size() && i < exp_sends.size(); i++) begin
      check_value("send_data", got_sends[i], exp_sends[i]);
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, test_errors);
  endtask

  // Answers each request after a random delay and watches the four phases
  task automatic respond_to_sends();
    core_pkg::word_t held;
    int delay;
    int i;
    forever begin
      @(negedge clk);
      if (rst_n && send_req && !send_ack) begin
        held = send_data;
        got_sends.push_back(held);
        delay = xorshift() % 6;
        for (i = 0; i < delay; i++) begin
          @(negedge clk);
          assert (send_req) else begin
            $display("send_req dropped before send_ack was raised");
            test_errors++;
          end
          check_value("send_data", send_data, held);
        end
        send_ack = 1'b1;
        i = 0;
        while (send_req && i < ACK_TIMEOUT) begin
          check_value("send_data", send_data, held);
          @(negedge clk);
          i++;
        end
        assert (!send_req) else begin
          $display("timed out waiting for send_req to drop after send_ack");
          test_errors++;
        end
        delay = xorshift() % 4;
        repeat (delay) @(negedge clk);
        send_ack = 1'b0;
      end
    end
  endtask

  initial respond_to_sends();

  task automatic test_reset_state();
    start_test();
    emit(`CORE_OP_NOP);
    emit(`CORE_OP_NOP);
    emit(`CORE_OP_NOP);
    release_reset();
    @(negedge clk);
    check_idle_outputs();
    wait_for_stop();
    check_results();
    finish_test("reset_state");
  endtask

  task automatic test_arith_and_writes();
    start_test();
    binop(7'd20, 7'd7, `CORE_OP_ADD);
    store_top(7'h01, alu_rule(`CORE_OP_ADD, 32'd20, 32'd7));
    binop(7'd20, 7'd7, `CORE_OP_SUB);
    store_top(7'h02, alu_rule(`CORE_OP_SUB, 32'd20, 32'd7));
    binop(7'h5a, 7'h3c, `CORE_OP_AND);
    store_top(7'h03, alu_rule(`CORE_OP_AND, 32'h5a, 32'h3c));
    binop(7'h5a, 7'h3c, `CORE_OP_OR);
    store_top(7'h04, alu_rule(`CORE_OP_OR, 32'h5a, 32'h3c));
    binop(7'h5a, 7'h3c, `CORE_OP_XOR);
    store_top(7'h05, alu_rule(`CORE_OP_XOR, 32'h5a, 32'h3c));
    push_imm(7'd9);
    emit(`CORE_OP_DUP);
    emit(`CORE_OP_ADD);
    store_top(7'h06, alu_rule(`CORE_OP_ADD, 32'd9, 32'd9));
    emit(`CORE_OP_STOP);
    release_reset();
    wait_for_stop();
    check_results();
    finish_test("arith_and_writes");
  endtask

  task automatic test_carry_and_jumps();
    int taken_pos;
    int fall_pos;
    int jmp_pos;
    start_test();
    // 3 minus 5 borrows, so carry is set and the first JC is taken
    binop(7'd3, 7'd5, `CORE_OP_SUB);
    emit(`CORE_OP_DROP);
    taken_pos = load_ptr;
    push_imm(7'd0);
    emit(`CORE_OP_JC);
    push_imm(7'h60);
    push_imm(7'h61);
    emit(`CORE_OP_WRITE);
    prog_mem[taken_pos] = `CORE_PUSHI_FLAG | 8'(load_ptr);
    binop(7'd10, 7'd20, `CORE_OP_ADDC);
    store_top(7'h10, 32'd10 + 32'd20 + 32'd1);
    // Set carry again so the plain add has something to clear
    binop(7'd0, 7'd1, `CORE_OP_SUB);
    emit(`CORE_OP_DROP);
    binop(7'd1, 7'd2, `CORE_OP_ADD);
    store_top(7'h11, 32'd3);
    fall_pos = load_ptr;
    push_imm(7'd0);
    emit(`CORE_OP_JC);
    push_imm(7'h44);
    store_top(7'h12, 32'h44);
    jmp_pos = load_ptr;
    push_imm(7'd0);
    emit(`CORE_OP_JMP);
    // A wrongly taken JC lands in this skipped block
    prog_mem[fall_pos] = `CORE_PUSHI_FLAG | 8'(load_ptr);
    push_imm(7'h62);
    push_imm(7'h63);
    emit(`CORE_OP_WRITE);
    prog_mem[jmp_pos] = `CORE_PUSHI_FLAG | 8'(load_ptr);
    emit(`CORE_OP_STOP);
    release_reset();
    wait_for_stop();
    check_results();
    finish_test("carry_and_jumps");
  endtask

  task automatic test_send_handshake();
    start_test();
    push_imm(7'h11);
    push_imm(7'h22);
    push_imm(7'h33);
    emit(`CORE_OP_SEND);
    emit(`CORE_OP_SEND);
    push_imm(7'h44);
    emit(`CORE_OP_SEND);
    // Only the first word is left once all three sends have popped
    store_top(7'h05, 32'h11);
    emit(`CORE_OP_STOP);
    exp_sends.push_back(32'h33);
    exp_sends.push_back(32'h22);
    exp_sends.push_back(32'h44);
    release_reset();
    wait_for_stop();
    check_results();
    finish_test("send_handshake");
  endtask

  task automatic test_faults();
    int i;
    start_test();
    emit(`CORE_OP_DROP);
    binop(7'd1, 7'd2, `CORE_OP_WRITE);
    release_reset();
    wait_for_stop();
    check_value("fault", fault, core_pkg::fault_underflow);
    check_results();
    finish_test("underflow_fault");
    start_test();
    for (i = 0; i < 17; i++) begin
      push_imm(7'(i));
    end
    emit(`CORE_OP_WRITE);
    release_reset();
    wait_for_stop();
    check_value("fault", fault, core_pkg::fault_overflow);
    check_results();
    finish_test("overflow_fault");
  endtask

  initial begin
    rst_n = 1'b0;
    send_ack = 1'b0;
    test_reset_state();
    test_arith_and_writes();
    test_carry_and_jumps();
    test_send_handshake();
    test_faults();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and address widths of the core
`define CORE_WORD_WIDTH       32
`define CORE_PROG_ADDR_WIDTH  8
`define CORE_MEM_ADDR_WIDTH   8

// The data stack holds 2**CORE_DSTACK_DEPTH_LOG words
`define CORE_DSTACK_DEPTH_LOG 4

// Instruction codes with bit 7 clear
`define CORE_OP_NOP    8'h00
`define CORE_OP_ADD    8'h01
`define CORE_OP_ADDC   8'h02
`define CORE_OP_SUB    8'h03
`define CORE_OP_AND    8'h04
`define CORE_OP_OR     8'h05
`define CORE_OP_XOR    8'h06
`define CORE_OP_DUP    8'h07
`define CORE_OP_DROP   8'h08
`define CORE_OP_JMP    8'h09
`define CORE_OP_JC     8'h0a
`define CORE_OP_WRITE  8'h0b
`define CORE_OP_SEND   8'h0c
`define CORE_OP_STOP   8'h0d

// PUSHI sets bit 7 and carries a 7-bit immediate below it
`define CORE_PUSHI_FLAG 8'h80

// ALU operation select codes
`define CORE_ALU_ADD   3'd0
`define CORE_ALU_ADDC  3'd1
`define CORE_ALU_SUB   3'd2
`define CORE_ALU_AND   3'd3
`define CORE_ALU_OR    3'd4
`define CORE_ALU_XOR   3'd5

`endif

//--- sim.f
+incdir+include
src/core_pkg.sv
src/fetch_unit.sv
src/execute_control.sv
src/alu.sv
src/data_stack.sv
src/core_bus_port.sv
src/core_top.sv
dv/core_tb.sv

//--- src/alu.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  logic              carry_in,
  input  core_pkg::alu_op_t op,
  output core_pkg::word_t   result,
  output logic              carry_out
);

  // One extra bit on top holds the carry or the borrow
  typedef logic [`CORE_WORD_WIDTH:0] wide_t;

  wide_t wide;

  always_comb begin
    case (op)
      `CORE_ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
      end
      `CORE_ALU_ADDC: begin
        wide = {1'b0, a} + {1'b0, b} + wide_t'(carry_in);
      end
      // Wraps past zero when b is larger, which sets the top bit as borrow
      `CORE_ALU_SUB: begin
        wide = {1'b0, a} - {1'b0, b};
      end
      `CORE_ALU_AND: begin
        wide = {1'b0, a & b};
      end
      `CORE_ALU_OR: begin
        wide = {1'b0, a | b};
      end
      `CORE_ALU_XOR: begin
        wide = {1'b0, a ^ b};
      end
      default: begin
        wide = '0;
      end
    endcase
  end

  assign result    = wide[`CORE_WORD_WIDTH-1:0];
  assign carry_out = wide[`CORE_WORD_WIDTH];

endmodule

//--- src/core_bus_port.sv
`timescale 1ns/100ps

module core_bus_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 write_go,
  input  logic                 send_go,
  input  core_pkg::word_t      top,
  input  core_pkg::word_t      second,
  input  logic                 send_ack,
  output core_pkg::mem_write_t mem_write,
  output logic                 send_req,
  output core_pkg::word_t      send_data,
  output logic                 send_done
);

  logic                  write_we;
  core_pkg::mem_addr_t   write_addr;
  core_pkg::word_t       write_data;
  core_pkg::send_state_t state;
  core_pkg::send_state_t state_next;

  // Address comes from top and data from second, one cycle after WRITE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_we <= 1'b0;
    end else begin
      write_we <= write_go;
    end
  end

  always_ff @(posedge clk) begin
    if (write_go) begin
      write_addr <= core_pkg::mem_addr_t'(top);
      write_data <= second;
    end
  end

  assign mem_write = '{we: write_we, addr: write_addr, data: write_data};

  always_comb begin
    state_next = state;
    case (state)
      core_pkg::send_idle: begin
        if (send_go) begin
          state_next = core_pkg::send_req_high;
        end
      end
      core_pkg::send_req_high: begin
        if (send_ack) begin
          state_next = core_pkg::send_wait_low;
        end
      end
      core_pkg::send_wait_low: begin
        if (!send_ack) begin
          state_next = core_pkg::send_done;
        end
      end
      default: begin
        state_next = core_pkg::send_idle;
      end
    endcase
  end

  // req comes straight from a flop so the bus never sees a decode glitch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= core_pkg::send_idle;
      send_req <= 1'b0;
    end else begin
      state    <= state_next;
      send_req <= (state_next == core_pkg::send_req_high);
    end
  end

  // The word stays put from the request until the next SEND starts
  always_ff @(posedge clk) begin
    if (state == core_pkg::send_idle && send_go) begin
      send_data <= top;
    end
  end

  assign send_done = (state == core_pkg::send_done);

endmodule

//--- src/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  // Plain vectors whose width carries a meaning
  typedef logic [`CORE_WORD_WIDTH-1:0]      word_t;
  typedef logic [`CORE_PROG_ADDR_WIDTH-1:0] prog_addr_t;
  typedef logic [`CORE_MEM_ADDR_WIDTH-1:0]  mem_addr_t;
  typedef logic [7:0]                       instr_t;
  typedef logic [2:0]                       alu_op_t;

  // Status code shown on the fault port until the next reset
  typedef enum logic [1:0] {
    fault_none      = 2'd0,
    fault_overflow  = 2'd1,
    fault_underflow = 2'd2
  } fault_t;

  // What the data stack does on a committed edge
  // Pops are applied before the push
  typedef struct packed {
    logic [1:0] pop_count;
    logic       push;
    word_t      push_value;
  } stack_op_t;

  // One main-memory write
  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    word_t     data;
  } mem_write_t;

  // Four-phase send handshake
  typedef enum logic [1:0] {
    send_idle     = 2'd0,
    send_req_high = 2'd1,
    send_wait_low = 2'd2,
    send_done     = 2'd3
  } send_state_t;

endpackage

//--- src/core_top.sv
`timescale 1ns/100ps

module core_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::instr_t     program_data,
  input  logic                 send_ack,
  output core_pkg::prog_addr_t program_addr,
  output core_pkg::mem_write_t mem_write,
  output logic                 send_req,
  output core_pkg::word_t      send_data,
  output logic                 stopped,
  output core_pkg::fault_t     fault
);

  core_pkg::instr_t     instruction;
  core_pkg::prog_addr_t jump_target;
  core_pkg::word_t      top;
  core_pkg::word_t      second;
  core_pkg::word_t      alu_result;
  core_pkg::alu_op_t    alu_op;
  core_pkg::stack_op_t  stack_op;
  logic                 halt;
  logic                 jump;
  logic                 carry;
  logic                 alu_carry;
  logic                 overflow;
  logic                 underflow;
  logic                 write_go;
  logic                 send_go;
  logic                 send_done;

  // Input side
  fetch_unit u_fetch (
    .clk, .rst_n, .program_data, .halt, .jump, .jump_target,
    .program_addr, .instruction
  );

  // Processing part
  execute_control u_control (
    .clk, .rst_n, .instruction, .top, .second, .alu_result, .alu_carry,
    .overflow, .underflow, .send_done, .alu_op, .carry, .stack_op, .halt,
    .jump, .jump_target, .write_go, .send_go, .stopped, .fault
  );

  // second is the left operand so SUB computes second minus top
  alu u_alu (
    .a(second), .b(top), .carry_in(carry), .op(alu_op),
    .result(alu_result), .carry_out(alu_carry)
  );

  // A halted cycle leaves the stack as it is
  data_stack u_stack (
    .clk, .rst_n, .stack_op, .commit(!halt), .top, .second,
    .empty(), .overflow, .underflow
  );

  // Output side
  core_bus_port u_bus_port (
    .clk, .rst_n, .write_go, .send_go, .top, .second, .send_ack,
    .mem_write, .send_req, .send_data, .send_done
  );

endmodule

//--- src/data_stack.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module data_stack (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::stack_op_t stack_op,
  input  logic                commit,
  output core_pkg::word_t     top,
  output core_pkg::word_t     second,
  output logic                empty,
  output logic                overflow,
  output logic                underflow
);

  localparam int DEPTH = 1 << `CORE_DSTACK_DEPTH_LOG;

  // The count needs one bit more than the index to reach DEPTH
  typedef logic [`CORE_DSTACK_DEPTH_LOG-1:0] index_t;
  typedef logic [`CORE_DSTACK_DEPTH_LOG:0]   count_t;

  core_pkg::word_t entries [DEPTH];
  count_t          count;
  count_t          after_pop;
  count_t          count_next;
  index_t          top_index;
  index_t          second_index;
  logic            apply;

  // Entry count-1 is the top of the stack
  assign top_index    = index_t'(count - count_t'(1));
  assign second_index = index_t'(count - count_t'(2));
  assign top          = entries[top_index];
  assign second       = entries[second_index];
  assign empty        = (count == '0);

  // Depth checks for the operation proposed in this cycle
  assign after_pop  = count - count_t'(stack_op.pop_count);
  assign count_next = after_pop + count_t'(stack_op.push);
  assign underflow  = count_t'(stack_op.pop_count) > count;
  assign overflow   = stack_op.push && (after_pop == count_t'(DEPTH));

  // An operation that would overrun either end never touches the stack
  assign apply = commit && !overflow && !underflow;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (apply) begin
      count <= count_next;
    end
  end

  // After the pops the new top lands right above the remaining entries
  always_ff @(posedge clk) begin
    if (apply && stack_op.push) begin
      entries[index_t'(after_pop)] <= stack_op.push_value;
    end
  end

endmodule

//--- src/execute_control.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module execute_control (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::instr_t     instruction,
  input  core_pkg::word_t      top,
  input  core_pkg::word_t      second,
  input  core_pkg::word_t      alu_result,
  input  logic                 alu_carry,
  input  logic                 overflow,
  input  logic                 underflow,
  input  logic                 send_done,
  output core_pkg::alu_op_t    alu_op,
  output logic                 carry,
  output core_pkg::stack_op_t  stack_op,
  output logic                 halt,
  output logic                 jump,
  output core_pkg::prog_addr_t jump_target,
  output logic                 write_go,
  output logic                 send_go,
  output logic                 stopped,
  output core_pkg::fault_t     fault
);

  logic use_alu;
  logic carry_we;
  logic is_jump;
  logic is_write;
  logic is_send;
  logic is_stop;
  logic fault_now;
  logic active;

  always_comb begin
    stack_op = '0;
    alu_op   = `CORE_ALU_ADD;
    use_alu  = 1'b0;
    carry_we = 1'b0;
    is_jump  = 1'b0;
    is_write = 1'b0;
    is_send  = 1'b0;
    is_stop  = 1'b0;
    if ((instruction & `CORE_PUSHI_FLAG) != '0) begin
      stack_op.push       = 1'b1;
      stack_op.push_value = core_pkg::word_t'(instruction & ~`CORE_PUSHI_FLAG);
    end else begin
      case (instruction)
        `CORE_OP_ADD: begin
          alu_op   = `CORE_ALU_ADD;
          use_alu  = 1'b1;
          carry_we = 1'b1;
        end
        `CORE_OP_ADDC: begin
          alu_op   = `CORE_ALU_ADDC;
          use_alu  = 1'b1;
          carry_we = 1'b1;
        end
        `CORE_OP_SUB: begin
          alu_op   = `CORE_ALU_SUB;
          use_alu  = 1'b1;
          carry_we = 1'b1;
        end
        `CORE_OP_AND: begin
          alu_op  = `CORE_ALU_AND;
          use_alu = 1'b1;
        end
        `CORE_OP_OR: begin
          alu_op  = `CORE_ALU_OR;
          use_alu = 1'b1;
        end
        `CORE_OP_XOR: begin
          alu_op  = `CORE_ALU_XOR;
          use_alu = 1'b1;
        end
        `CORE_OP_DUP: begin
          stack_op.push       = 1'b1;
          stack_op.push_value = top;
        end
        `CORE_OP_DROP: stack_op.pop_count = 2'd1;
        `CORE_OP_JMP: begin
          stack_op.pop_count = 2'd1;
          is_jump            = 1'b1;
        end
        // JC pops its target whether or not the jump is taken
        `CORE_OP_JC: begin
          stack_op.pop_count = 2'd1;
          is_jump            = carry;
        end
        `CORE_OP_WRITE: begin
          stack_op.pop_count = 2'd2;
          is_write           = 1'b1;
        end
        // The pop only lands in the send_done cycle because halt blocks it before
        `CORE_OP_SEND: begin
          stack_op.pop_count = 2'd1;
          is_send            = 1'b1;
        end
        `CORE_OP_STOP: is_stop = 1'b1;
        // NOP and unassigned codes do nothing
        default: stack_op = '0;
      endcase
      // Binary ops consume second and top and leave the result on top
      if (use_alu) begin
        stack_op.pop_count  = 2'd2;
        stack_op.push       = 1'b1;
        stack_op.push_value = alu_result;
      end
    end
  end

  // A faulting instruction has no effect at all
  assign fault_now   = !stopped && (overflow || underflow);
  assign active      = !stopped && !fault_now;
  assign send_go     = is_send && active;
  assign write_go    = is_write && active;
  assign jump        = is_jump && active;
  assign jump_target = top[`CORE_PROG_ADDR_WIDTH-1:0];

  // STOP and a fault freeze the PC on the same edge that sets stopped
  assign halt = stopped || fault_now || is_stop || (send_go && !send_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry   <= 1'b0;
      stopped <= 1'b0;
      fault   <= core_pkg::fault_none;
    end else begin
      if (carry_we && !halt) begin
        carry <= alu_carry;
      end
      if (fault_now) begin
        stopped <= 1'b1;
        fault   <= overflow ? core_pkg::fault_overflow : core_pkg::fault_underflow;
      end else if (is_stop) begin
        stopped <= 1'b1;
      end
    end
  end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::instr_t     program_data,
  input  logic                 halt,
  input  logic                 jump,
  input  core_pkg::prog_addr_t jump_target,
  output core_pkg::prog_addr_t program_addr,
  output core_pkg::instr_t     instruction
);

  // Address of the instruction that is current in this cycle
  core_pkg::prog_addr_t pc;
  core_pkg::prog_addr_t pc_next;

  // The program memory reads on every edge, reset included
  // Holding address 0 during reset puts instruction 0 on program_data
  // in the first cycle after reset
  always_comb begin
    if (!rst_n) begin
      pc_next = '0;
    end else if (halt) begin
      pc_next = pc;
    end else if (jump) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // The memory answers one clock later, so the returned byte belongs to pc
  assign program_addr = pc_next;
  assign instruction  = program_data;

endmodule
